/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP = tbIssueFrontEnd
FILELIST = filelist.f
BUILD = obj_dir
SIM = $(BUILD)/V$(TOP)
LOG = sim.log
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* common/isaPkg.sv */
/*
 * ISA constants for the issue front end: 16-bit words, opcode in the top five bits
 * eight registers, so every register field is three bits wide
 * only the fields that the hazard logic needs are described here
 */
`default_nettype none

package isaPkg;

    localparam int opWidth = 5;
    localparam int instWidth = 16;
    localparam int regAddrWidth = 3;

    // low bit of each register field
    localparam int rsLsb = 8;
    localparam int rtLsb = 5;
    // r-format destination sits below rt
    localparam int rdLsb = 2;

    // system group, 000xx
    localparam logic [opWidth-1:0] haltOp = 5'b00000;
    localparam logic [opWidth-1:0] nopOp = 5'b00001;
    localparam logic [opWidth-1:0] siicOp = 5'b00010;
    localparam logic [opWidth-1:0] rtiOp = 5'b00011;

    // bubble inserted on every stall
    localparam logic [instWidth-1:0] nopWord = {nopOp, {(instWidth - opWidth){1'b0}}};

    // single opcodes with their own rules
    localparam logic [opWidth-1:0] stOp = 5'b10000;
    localparam logic [opWidth-1:0] stuOp = 5'b10011;
    localparam logic [opWidth-1:0] slbiOp = 5'b10010;
    localparam logic [opWidth-1:0] lbiOp = 5'b11000;
    localparam logic [opWidth-1:0] bitOp = 5'b11010;
    localparam logic [opWidth-1:0] arithOp = 5'b11011;

    // opcode prefixes for whole classes
    localparam logic [2:0] sysPfx = 3'b000;
    localparam logic [2:0] jumpPfx = 3'b001;
    localparam logic [2:0] branchPfx = 3'b011;
    localparam logic [2:0] setPfx = 3'b111;
    localparam logic [3:0] plainJmpPfx = 4'b0010;
    localparam logic [3:0] linkJmpPfx = 4'b0011;
    localparam logic [1:0] rFmtPfx = 2'b11;

    // jal and jalr return address
    localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

    // class rules
    // st reads rs and rd, writes nothing
    // stu reads rs and rd, writes rs
    // arith, bit ops, set read rs and rt, write rd at bits 4:2
    // lbi reads nothing, writes rs; slbi reads rs, writes rs
    // nop, siic, rti read nothing, write nothing; halt stops issue
    // 011xx branch reads rs, writes nothing
    // 001xx jump reads rs, j/jr write nothing, jal/jalr write r7
    // everything else reads rs, writes the field at bits 7:5

endpackage

`default_nettype wire

/* filelist.f */
common/isaPkg.sv
rtl/instDecode.sv
hazard/stageTracker.sv
hazard/hazardDetect.sv
rtl/fetchBuffer.sv
rtl/issueFrontEnd.sv
verif/clockGen.sv
verif/tbIssueFrontEnd.sv

/* hazard/hazardDetect.sv */
/*
 * Issue decision for the buffered word, one word or bubble per cycle
 * checks only the tracked stages; W is not checked because the
 * register file writes before it reads
 * a buffered halt is never issued and locks the front end for good
 */
`default_nettype none

module hazardDetect import isaPkg::*; #(
    parameter int trackDepth = 3
) (
    input wire clk,
    input wire arstN,
    input wire bufValid,
    input wire [instWidth-1:0] bufWord,
    input wire readsRs,
    input wire readsSecond,
    input wire [regAddrWidth-1:0] secondReg,
    input wire isBranch,
    input wire isHalt,
    input wire [trackDepth-1:0] regWrt,
    input wire [trackDepth-1:0][regAddrWidth-1:0] wrtReg,
    input wire [trackDepth-1:0] branchInst,
    output logic issueNow,
    output logic [instWidth-1:0] issueWord,
    output logic issueValid,
    output logic halted
);

    logic [regAddrWidth-1:0] rsField;
    logic rsHit;
    logic secondHit;
    logic branchBusy;
    logic stall;

    assign rsField = bufWord[rsLsb +: regAddrWidth];

    // compare both sources against every in-flight writer
    always_comb begin
        rsHit = 1'b0;
        secondHit = 1'b0;
        branchBusy = 1'b0;
        for (int k = 0; k < trackDepth; k++) begin
            if (regWrt[k] && wrtReg[k] == rsField) begin
                rsHit = 1'b1;
            end
            if (regWrt[k] && wrtReg[k] == secondReg) begin
                secondHit = 1'b1;
            end
            // any branch still between D and M
            if (branchInst[k]) begin
                branchBusy = 1'b1;
            end
        end
        // fields the class does not read never collide
        rsHit = rsHit && readsRs;
        secondHit = secondHit && readsSecond;
    end

    always_comb begin
        if (isHalt) begin
            stall = 1'b1;
        end else if (isBranch) begin
            // branches and jumps wait only for their own operand
            stall = rsHit;
        end else begin
            stall = rsHit || secondHit || branchBusy;
        end
    end

    // empty buffer falls through to a bubble
    assign issueNow = bufValid && !stall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueWord <= nopWord;
            issueValid <= 1'b0;
            halted <= 1'b0;
        end else begin
            issueWord <= issueNow ? bufWord : nopWord;
            issueValid <= issueNow;
            // sticky, the halt word stays parked in the buffer
            if (bufValid && isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hazard/stageTracker.sv */
/*
 * Write and branch records of issued words, index 0 is D
 * entry 0 follows the word on issueWord directly, older entries are flops
 * trackDepth must be at least 2
 */
`default_nettype none

module stageTracker import isaPkg::*; #(
    parameter int trackDepth = 3
) (
    input wire clk,
    input wire arstN,
    input wire issueValid,
    input wire writesReg,
    input wire [regAddrWidth-1:0] wrtRegIn,
    input wire isBranch,
    output logic [trackDepth-1:0] regWrt,
    output logic [trackDepth-1:0][regAddrWidth-1:0] wrtReg,
    output logic [trackDepth-1:0] branchInst
);

    // X, M and beyond
    logic [trackDepth-1:1] regWrtQ;
    logic [trackDepth-1:1] branchQ;
    logic [trackDepth-1:1][regAddrWidth-1:0] wrtRegQ;

    // D stage, a bubble carries an empty record
    assign regWrt[0] = issueValid && writesReg;
    assign branchInst[0] = issueValid && isBranch;
    assign wrtReg[0] = wrtRegIn;

    assign regWrt[trackDepth-1:1] = regWrtQ;
    assign branchInst[trackDepth-1:1] = branchQ;
    assign wrtReg[trackDepth-1:1] = wrtRegQ;

    // flags shift one stage per cycle, oldest falls off past M
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWrtQ <= '0;
            branchQ <= '0;
        end else begin
            regWrtQ <= regWrt[trackDepth-2:0];
            branchQ <= branchInst[trackDepth-2:0];
        end
    end

    // register index only matters while its flag is set
    always_ff @(posedge clk) begin
        wrtRegQ <= wrtReg[trackDepth-2:0];
    end

endmodule

`default_nettype wire

/* rtl/fetchBuffer.sv */
/*
 * One-entry skid for the instruction stream, valid/ready on the input
 * instReady is combinational from issueNow, so a word can move in
 * the same cycle the old one leaves; nothing is accepted after a halt
 */
`default_nettype none

module fetchBuffer import isaPkg::*; (
    input wire clk,
    input wire arstN,
    input wire instValid,
    input wire [instWidth-1:0] instWord,
    output logic instReady,
    input wire issueNow,
    input wire halted,
    output logic bufValid,
    output logic [instWidth-1:0] bufWord
);

    logic take;

    // room when empty or when the held word issues this cycle
    assign instReady = !halted && (!bufValid || issueNow);
    assign take = instValid && instReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bufValid <= 1'b0;
        end else if (take) begin
            bufValid <= 1'b1;
        end else if (issueNow) begin
            // drained with nothing behind it
            bufValid <= 1'b0;
        end
    end

    // held unchanged through stalls
    always_ff @(posedge clk) begin
        if (take) begin
            bufWord <= instWord;
        end
    end

endmodule

`default_nettype wire

/* rtl/instDecode.sv */
/*
 * Purely combinational classifier, one opcode class per word
 * second source is always the 7:5 field (rt, or rd for stores)
 * halt decodes like any rs reader; the detector blocks it separately
 */
`default_nettype none

module instDecode import isaPkg::*; (
    input wire [instWidth-1:0] instWord,
    output logic readsRs,
    output logic readsSecond,
    output logic [regAddrWidth-1:0] secondReg,
    output logic writesReg,
    output logic [regAddrWidth-1:0] wrtReg,
    output logic isBranch,
    output logic isHalt
);

    logic [opWidth-1:0] op;
    logic [3:0] opPfx4;
    logic [2:0] opPfx3;
    logic [1:0] opPfx2;
    logic [regAddrWidth-1:0] rsField;
    logic [regAddrWidth-1:0] rtField;
    logic [regAddrWidth-1:0] rdField;

    assign op = instWord[instWidth-1 -: opWidth];
    assign opPfx4 = op[opWidth-1 -: 4];
    assign opPfx3 = op[opWidth-1 -: 3];
    assign opPfx2 = op[opWidth-1 -: 2];

    assign rsField = instWord[rsLsb +: regAddrWidth];
    assign rtField = instWord[rtLsb +: regAddrWidth];
    assign rdField = instWord[rdLsb +: regAddrWidth];

    // stores and r-format share the same slot for their second operand
    assign secondReg = rtField;
    assign isHalt = (op == haltOp);

    always_comb begin
        readsRs = 1'b1;
        readsSecond = 1'b0;
        writesReg = 1'b1;
        wrtReg = rtField;
        isBranch = 1'b0;

        // words with no source operand
        if (op == lbiOp || op == nopOp || op == siicOp || op == rtiOp) begin
            readsRs = 1'b0;
        end

        // two-source classes
        if (op == stOp || op == stuOp || op == arithOp || op == bitOp || opPfx3 == setPfx) begin
            readsSecond = 1'b1;
        end

        // branches and all four jumps open the control window
        if (opPfx3 == branchPfx || opPfx3 == jumpPfx) begin
            isBranch = 1'b1;
        end

        // no destination
        if (op == stOp || opPfx3 == branchPfx || opPfx4 == plainJmpPfx || opPfx3 == sysPfx) begin
            writesReg = 1'b0;
        end

        // destination field; lbi must be caught before the r-format test
        if (op == lbiOp || op == slbiOp || op == stuOp) begin
            wrtReg = rsField;
        end else if (opPfx4 == linkJmpPfx) begin
            wrtReg = linkReg;
        end else if (opPfx2 == rFmtPfx) begin
            wrtReg = rdField;
        end
    end

endmodule

`default_nettype wire

/* rtl/issueFrontEnd.sv */
/*
 * Issue front end: fetch buffer, two decoders, hazard detector, stage tracker
 * issueWord is registered and enters D every cycle, real or bubble
 * branch resolution and everything past D live outside this block
 */
`default_nettype none

module issueFrontEnd import isaPkg::*; #(
    parameter int trackDepth = 3
) (
    input wire clk,
    input wire arstN,
    input wire instValid,
    input wire [instWidth-1:0] instWord,
    output logic instReady,
    output logic [instWidth-1:0] issueWord,
    output logic issueValid,
    output logic halted
);

    logic bufValid;
    logic [instWidth-1:0] bufWord;
    logic issueNow;

    // fetch-side decode of the buffered word
    logic fReadsRs;
    logic fReadsSecond;
    logic [regAddrWidth-1:0] fSecondReg;
    logic fIsBranch;
    logic fIsHalt;

    // issue-side decode of the word now in D
    logic iWritesReg;
    logic [regAddrWidth-1:0] iWrtReg;
    logic iIsBranch;

    logic [trackDepth-1:0] trkRegWrt;
    logic [trackDepth-1:0][regAddrWidth-1:0] trkWrtReg;
    logic [trackDepth-1:0] trkBranch;

    fetchBuffer uFetchBuffer (
        .clk(clk),
        .arstN(arstN),
        .instValid(instValid),
        .instWord(instWord),
        .instReady(instReady),
        .issueNow(issueNow),
        .halted(halted),
        .bufValid(bufValid),
        .bufWord(bufWord)
    );

    instDecode uFetchDecode (
        .instWord(bufWord),
        .readsRs(fReadsRs),
        .readsSecond(fReadsSecond),
        .secondReg(fSecondReg),
        .writesReg(),
        .wrtReg(),
        .isBranch(fIsBranch),
        .isHalt(fIsHalt)
    );

    hazardDetect #(
        .trackDepth(trackDepth)
    ) uHazardDetect (
        .clk(clk),
        .arstN(arstN),
        .bufValid(bufValid),
        .bufWord(bufWord),
        .readsRs(fReadsRs),
        .readsSecond(fReadsSecond),
        .secondReg(fSecondReg),
        .isBranch(fIsBranch),
        .isHalt(fIsHalt),
        .regWrt(trkRegWrt),
        .wrtReg(trkWrtReg),
        .branchInst(trkBranch),
        .issueNow(issueNow),
        .issueWord(issueWord),
        .issueValid(issueValid),
        .halted(halted)
    );

    instDecode uIssueDecode (
        .instWord(issueWord),
        .readsRs(),
        .readsSecond(),
        .secondReg(),
        .writesReg(iWritesReg),
        .wrtReg(iWrtReg),
        .isBranch(iIsBranch),
        .isHalt()
    );

    stageTracker #(
        .trackDepth(trackDepth)
    ) uStageTracker (
        .clk(clk),
        .arstN(arstN),
        .issueValid(issueValid),
        .writesReg(iWritesReg),
        .wrtRegIn(iWrtReg),
        .isBranch(iIsBranch),
        .regWrt(trkRegWrt),
        .wrtReg(trkWrtReg),
        .branchInst(trkBranch)
    );

endmodule

`default_nettype wire

/* verif/clockGen.sv */
/*
 * testbench clock and reset source
 * 100 ns period, reset held low for two rising edges
 * reset is released on a falling edge, away from the active edge
 */
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/issue_testdata.txt */
# seq <name> <expected bubbles under dense feed>, then w <hex word> lines, then end
# word layout: op[15:11] rs[10:8] rt/rd[7:5] rd[4:2]
seq independent 0
w 4020
w 4260
w 44A0
w 46E0
end
seq rsHazardD 3
w 4020
w 4140
end
seq rsHazardX 2
w 4020
w 4260
w 4140
end
seq rsHazardM 1
w 4020
w 4260
w 44A0
w 4140
end
seq writerInW 0
w 4020
w 4260
w 44A0
w 46E0
w 4140
end
seq arithRt 3
w 4020
w DA2C
end
seq storeRd 3
w 4020
w 8220
end
seq lbiNoRead 0
w 4020
w C1FF
end
seq arithRdWrite 3
w DA70
w 44A0
end
seq chainedStalls 6
w 4020
w 4140
w 4260
end
seq branchWindow 3
w 6004
w 4260
end
seq branchAfterBranch 0
w 6004
w 6104
end
seq branchRsHazard 3
w 4020
w 6104
end
seq jumpWindow 3
w 2000
w 4260
end
seq jalLinkReg 3
w 3000
w 4720
end

/* verif/tbIssueFrontEnd.sv */
/*
 * testbench for the issue front end with sequences from verif/issue_testdata.txt
 * a cycle model with its own D/X/M record predicts issueWord on falling edges
 * stall counts are checked only under dense feeding
 * the random-gap pass relies on the model alone
 */
`default_nettype none

module tbIssueFrontEnd import isaPkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int trackDepth = 3;
    localparam int waitLimit = 64;

    logic clk;
    logic arstN;
    logic instValid;
    logic [instWidth-1:0] instWord;
    logic instReady;
    logic [instWidth-1:0] issueWord;
    logic issueValid;
    logic halted;

    // model state updated only on falling edges
    logic mBufValid;
    logic [instWidth-1:0] mBufWord;
    logic [trackDepth-1:0] mWr;
    logic [regAddrWidth-1:0] mWreg [trackDepth];
    logic [trackDepth-1:0] mBr;
    logic mHalted;
    logic [instWidth-1:0] predWord;
    logic predValid;

    // per-sequence statistics
    string testName;
    int seqLen;
    int seqIssued;
    int seqBubbles;
    int realCnt;
    logic [instWidth-1:0] sentQ [$];
    logic [instWidth-1:0] seqWords [$];
    logic [instWidth-1:0] allWords [$];
    logic [15:0] lfsr;

    clockGen uClockGen (
        .clk(clk),
        .arstN(arstN)
    );

    issueFrontEnd #(
        .trackDepth(trackDepth)
    ) UUT (
        .clk(clk),
        .arstN(arstN),
        .instValid(instValid),
        .instWord(instWord),
        .instReady(instReady),
        .issueWord(issueWord),
        .issueValid(issueValid),
        .halted(halted)
    );

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "%s", msg);
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    // operand use per opcode class from the ISA table
    task automatic classify(input logic [instWidth-1:0] w, output logic rdA, output logic rdB,
                            output logic [2:0] regB, output logic wr, output logic [2:0] wreg,
                            output logic br, output logic hlt);
        logic [4:0] op;
        op = w[15:11];
        rdA = 1'b1;
        rdB = 1'b0;
        regB = w[7:5];
        wr = 1'b1;
        wreg = w[7:5];
        br = 1'b0;
        hlt = (op == 5'b00000);
        if (op == 5'b11000 || op == 5'b00001 || op == 5'b00010 || op == 5'b00011) begin
            rdA = 1'b0;
        end
        // st, stu, arith, bit ops, set
        if (op == 5'b10000 || op == 5'b10011 || op == 5'b11011 || op == 5'b11010
            || op[4:2] == 3'b111) begin
            rdB = 1'b1;
        end
        if (op[4:2] == 3'b011 || op[4:2] == 3'b001) begin
            br = 1'b1;
        end
        if (op == 5'b10000 || op[4:2] == 3'b011 || op[4:1] == 4'b0010 || op[4:2] == 3'b000) begin
            wr = 1'b0;
        end
        if (op == 5'b11000 || op == 5'b10010 || op == 5'b10011) begin
            wreg = w[10:8];
        end else if (op[4:1] == 4'b0011) begin
            wreg = 3'd7;
        end else if (op[4:3] == 2'b11) begin
            wreg = w[4:2];
        end
    endtask

    // reference model stepping once per cycle between edges
    always @(negedge clk) begin
        logic rdA;
        logic rdB;
        logic [2:0] regB;
        logic wr;
        logic [2:0] wreg;
        logic br;
        logic hlt;
        logic rsHit;
        logic secHit;
        logic busy;
        logic stall;
        logic issue;
        logic ready;
        if (!arstN) begin
            mBufValid = 1'b0;
            mBufWord = nopWord;
            mWr = '0;
            mBr = '0;
            mHalted = 1'b0;
            predWord = nopWord;
            predValid = 1'b0;
            realCnt = 0;
        end else begin
            checkVal({testName, " issueWord"}, 32'(predWord), 32'(issueWord));
            checkVal({testName, " issueValid"}, 32'(predValid), 32'(issueValid));
            checkVal({testName, " halted"}, 32'(mHalted), 32'(halted));
            checkVal({testName, " noHaltIssued"}, 32'(0), 32'(issueWord[15:11] == 5'b00000));
            if (issueValid) begin
                if (sentQ.size() == 0) begin
                    failNow("a real word issued that was never sent");
                end
                checkVal({testName, " issueOrder"}, 32'(sentQ.pop_front()), 32'(issueWord));
                realCnt++;
                seqIssued++;
            end else if (seqIssued > 0 && seqIssued < seqLen) begin
                seqBubbles++;
            end
            classify(mBufWord, rdA, rdB, regB, wr, wreg, br, hlt);
            rsHit = 1'b0;
            secHit = 1'b0;
            busy = 1'b0;
            for (int k = 0; k < trackDepth; k++) begin
                if (mWr[k] && mWreg[k] == mBufWord[10:8] && rdA) rsHit = 1'b1;
                if (mWr[k] && mWreg[k] == regB && rdB) secHit = 1'b1;
                if (mBr[k]) busy = 1'b1;
            end
            stall = hlt || (br ? rsHit : (rsHit || secHit || busy));
            issue = mBufValid && !stall;
            ready = !mHalted && (!mBufValid || issue);
            checkVal({testName, " instReady"}, 32'(ready), 32'(instReady));
            // shift records so the issued word enters D
            for (int k = trackDepth - 1; k > 0; k--) begin
                mWr[k] = mWr[k-1];
                mWreg[k] = mWreg[k-1];
                mBr[k] = mBr[k-1];
            end
            mWr[0] = issue && wr;
            mWreg[0] = wreg;
            mBr[0] = issue && br;
            if (mBufValid && hlt) begin
                mHalted = 1'b1;
            end
            predWord = issue ? mBufWord : nopWord;
            predValid = issue;
            if (instValid && ready) begin
                mBufValid = 1'b1;
                mBufWord = instWord;
            end else if (issue) begin
                mBufValid = 1'b0;
            end
        end
    end

    // drives the word until it transfers and returns just before the transfer edge
    task automatic sendWord(input logic [instWidth-1:0] w, input int gap, input logic track);
        int n;
        for (int g = 0; g < gap; g++) begin
            @(posedge clk);
            instValid <= 1'b0;
        end
        @(posedge clk);
        instValid <= 1'b1;
        instWord <= w;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > waitLimit) begin
                failNow("timeout waiting for instReady");
            end
        end while (!instReady);
        if (track) begin
            sentQ.push_back(w);
        end
    endtask

    task automatic waitDrained(input int target);
        int n;
        n = 0;
        while (realCnt < target || mBufValid) begin
            @(posedge clk);
            n++;
            if (n > waitLimit * 8) begin
                failNow("timeout waiting for words to issue");
            end
        end
        // let the last records leave M
        repeat (trackDepth + 1) @(posedge clk);
    endtask

    task automatic runSeq(input string name, input int expStalls);
        int target;
        testName = name;
        seqLen = seqWords.size();
        seqIssued = 0;
        seqBubbles = 0;
        target = realCnt + seqLen;
        foreach (seqWords[i]) begin
            sendWord(seqWords[i], 0, 1'b1);
            allWords.push_back(seqWords[i]);
        end
        @(posedge clk);
        instValid <= 1'b0;
        waitDrained(target);
        checkVal(name, 32'(expStalls), 32'(seqBubbles));
        seqWords.delete();
    endtask

    initial begin
        int fd;
        int code;
        int stalls;
        int gap;
        int target;
        int n;
        string line;
        string tag;
        string name;
        logic [instWidth-1:0] w;
        instValid = 1'b0;
        instWord = nopWord;
        testName = "reset";
        seqLen = 0;
        seqIssued = 0;
        seqBubbles = 0;
        lfsr = 16'd51901;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > waitLimit) begin
                failNow("timeout waiting for reset release");
            end
        end while (arstN !== 1'b1);
        @(negedge clk);
        checkVal("resetIssueValid", 32'(0), 32'(issueValid));
        checkVal("resetIssueWord", 32'(nopWord), 32'(issueWord));
        checkVal("resetInstReady", 32'(1), 32'(instReady));
        checkVal("resetHalted", 32'(0), 32'(halted));

        fd = $fopen("verif/issue_testdata.txt", "r");
        if (fd == 0) begin
            failNow("cannot open verif/issue_testdata.txt");
        end
        stalls = 0;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            tag = "";
            if (line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%s", tag);
            end
            if (tag == "seq") begin
                code = $sscanf(line, "%s %s %d", tag, name, stalls);
            end else if (tag == "w") begin
                code = $sscanf(line, "%s %h", tag, w);
                seqWords.push_back(w);
            end else if (tag == "end") begin
                runSeq(name, stalls);
            end
        end
        $fclose(fd);

        // same words again with random idle cycles
        testName = "randomGaps";
        seqLen = 0;
        target = realCnt + allWords.size();
        foreach (allWords[i]) begin
            gap = 0;
            for (int b = 0; b < 2; b++) begin
                lfsr = lfsrStep(lfsr);
                gap = gap | (int'(lfsr[0]) << b);
            end
            sendWord(allWords[i], gap, 1'b1);
        end
        @(posedge clk);
        instValid <= 1'b0;
        waitDrained(target);

        // halt parks in the buffer and blocks everything behind it
        testName = "halt";
        sendWord(16'h0000, 0, 1'b0);
        @(posedge clk);
        instValid <= 1'b1;
        instWord <= 16'h4260;
        n = 0;
        while (!halted) begin
            @(negedge clk);
            n++;
            if (n > waitLimit) begin
                failNow("timeout waiting for halted");
            end
        end
        repeat (8) begin
            @(negedge clk);
            checkVal("haltReady", 32'(0), 32'(instReady));
            checkVal("haltIssueValid", 32'(0), 32'(issueValid));
            checkVal("haltFlag", 32'(1), 32'(halted));
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
